/* sim.f */
hdl/fetch_ctrl_pkg.sv
hdl/fetch_bus_pkg.sv
hdl/fetch_cfg_regs.sv
hdl/fetch_pc_sel.sv
hdl/prefetch_buffer.sv
hdl/if_stage.sv
hdl/fetch_top.sv
testbench/tb_imem.sv
testbench/tb_fetch_top.sv

/* testbench/tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;

  logic                        clk;
  logic                        rst_n;
  logic                        req;
  logic                        pc_set;
  fetch_ctrl_pkg::pc_mux_e     pc_mux;
  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux;
  logic [4:0]                  irq_id;
  logic [31:0]                 mepc;
  logic [31:0]                 depc;
  logic [31:0]                 jump_target_id;
  logic [31:0]                 jump_target_ex;
  logic                        clear_instr_valid;
  logic                        halt_if;
  logic                        id_ready;
  fetch_bus_pkg::cfg_wr_t      cfg_wr;
  fetch_bus_pkg::instr_req_t   instr_req;
  fetch_bus_pkg::instr_rsp_t   instr_rsp;
  fetch_bus_pkg::if_id_t       if_id;
  logic                        if_busy;

  logic [31:0] sh_boot;     // reference copy of the config registers
  logic [23:0] sh_mtvec;
  logic [31:0] sh_dm_halt;
  logic [31:0] sh_dm_exc;
  logic [31:0] exp_pc;      // pc of the next instr expected in IF/ID
  logic [31:0] last_pc;     // pc of the last instr loaded into IF/ID
  logic [31:0] prev_pc;
  logic        prev_valid;
  logic [7:0]  rnd;
  int          n_loaded;
  int          checks;
  int          errors;
  int          test_errs;
  int          test_num;

  fetch_top dut0
  (
    .clk (clk), .rst_n (rst_n), .req_i (req), .pc_set_i (pc_set),
    .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_pc_mux), .irq_id_i (irq_id),
    .mepc_i (mepc), .depc_i (depc),
    .jump_target_id_i (jump_target_id), .jump_target_ex_i (jump_target_ex),
    .clear_instr_valid_i (clear_instr_valid), .halt_if_i (halt_if), .id_ready_i (id_ready),
    .cfg_wr_i (cfg_wr), .instr_req_o (instr_req), .instr_rsp_i (instr_rsp),
    .if_id_o (if_id), .if_busy_o (if_busy)
  );

  tb_imem imem0 (.clk (clk), .rst_n (rst_n), .instr_req_i (instr_req), .instr_rsp_o (instr_rsp));

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  function automatic logic [31:0] exp_target(input fetch_ctrl_pkg::pc_mux_e mux,
                                             input fetch_ctrl_pkg::exc_pc_mux_e exc,
                                             input logic [4:0] irq);
    logic [31:0] trap;
    logic [31:0] t;
    case (exc)
      fetch_ctrl_pkg::EXC_PC_IRQ: trap = {sh_mtvec, 1'b0, irq, 2'b00};  // vectored
      fetch_ctrl_pkg::EXC_PC_DBD: trap = sh_dm_halt;
      fetch_ctrl_pkg::EXC_PC_DBE: trap = sh_dm_exc;
      default:                    trap = {sh_mtvec, 8'h00};
    endcase
    case (mux)
      fetch_ctrl_pkg::PC_JUMP:      t = jump_target_id;
      fetch_ctrl_pkg::PC_BRANCH:    t = jump_target_ex;
      fetch_ctrl_pkg::PC_EXCEPTION: t = trap;
      fetch_ctrl_pkg::PC_MRET:      t = mepc;
      fetch_ctrl_pkg::PC_DRET:      t = depc;
      fetch_ctrl_pkg::PC_FENCEI:    t = last_pc + 32'd4;  // instr after the one in ID
      default:                      t = sh_boot;
    endcase
    return {t[31:2], 2'b00};
  endfunction

  // compare every newly loaded IF/ID entry, sampled mid-cycle
  always @(negedge clk)
  begin
    if (rst_n && if_id.valid && (!prev_valid || if_id.pc != prev_pc))
    begin
      checks++;
      assert (if_id.pc == exp_pc)
      else
      begin
        $display("Mismatch if_id_o.pc: got %h expected %h", if_id.pc, exp_pc);
        errors++;
      end
      assert (if_id.instr == imem0.mem_word(exp_pc))
      else
      begin
        $display("Mismatch if_id_o.instr: got %h expected %h", if_id.instr,
                 imem0.mem_word(exp_pc));
        errors++;
      end
      last_pc = exp_pc;
      exp_pc  = exp_pc + 32'd4;  // sequential stream
      n_loaded++;
    end
    prev_valid = if_id.valid;
    prev_pc    = if_id.pc;
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------

  task automatic cfg_write(input fetch_ctrl_pkg::cfg_addr_e a, input logic [31:0] d);
    @(posedge clk);
    cfg_wr <= '{we: 1'b1, addr: a, wdata: d};
    @(posedge clk);
    cfg_wr.we <= 1'b0;
    case (a)
      fetch_ctrl_pkg::CFG_BOOT_ADDR: sh_boot    = {d[31:2], 2'b00};
      fetch_ctrl_pkg::CFG_MTVEC:     sh_mtvec   = d[31:8];
      fetch_ctrl_pkg::CFG_DM_HALT:   sh_dm_halt = {d[31:2], 2'b00};
      default:                       sh_dm_exc  = {d[31:2], 2'b00};
    endcase
  endtask

  task automatic redirect(input fetch_ctrl_pkg::pc_mux_e mux,
                          input fetch_ctrl_pkg::exc_pc_mux_e exc, input logic [4:0] irq);
    @(posedge clk);
    pc_set            <= 1'b1;
    pc_mux            <= mux;
    exc_pc_mux        <= exc;
    irq_id            <= irq;
    clear_instr_valid <= 1'b1;  // kill the instr in ID as the controller would
    @(posedge clk);
    pc_set            <= 1'b0;
    clear_instr_valid <= 1'b0;
    exp_pc = exp_target(mux, exc, irq);  // DUT took the redirect at this edge
    if (mux == fetch_ctrl_pkg::PC_BOOT)
      sh_mtvec = sh_boot[31:8];  // trap base follows the boot address
  endtask

  task automatic wait_instrs(input int n);
    int target;
    int cycles;
    target = n_loaded + n;
    cycles = 0;
    while (n_loaded < target && cycles < 100 * n)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (n_loaded >= target)
    else
    begin
      $display("timeout after %0d cycles waiting for %0d instructions", cycles, n);
      errors++;
    end
  endtask

  // stall ID, wait for the bus to go idle, then resume
  task automatic stall_check(input logic use_halt);
    fetch_bus_pkg::if_id_t held;
    int cycles;
    @(posedge clk);
    if (use_halt)
      halt_if <= 1'b1;
    else
      id_ready <= 1'b0;
    @(negedge clk);
    held   = if_id;
    cycles = 0;
    while (if_busy && cycles < 50)
    begin
      @(negedge clk);
      cycles++;
      assert (if_id == held)
      else
      begin
        $display("Mismatch if_id_o: got %h expected %h", if_id, held);
        errors++;
      end
    end
    assert (!if_busy)
    else
    begin
      $display("bus still busy after %0d stalled cycles", cycles);
      errors++;
    end
    repeat (4)
    begin
      @(negedge clk);
      assert (!instr_req.req)
      else
      begin
        $display("Mismatch instr_req_o.req: got %h expected %h", instr_req.req, 1'b0);
        errors++;
      end
      assert (if_id == held)
      else
      begin
        $display("Mismatch if_id_o: got %h expected %h", if_id, held);
        errors++;
      end
    end
    @(posedge clk);
    halt_if  <= 1'b0;
    id_ready <= 1'b1;
    wait_instrs(8);  // fifo contents first, then fresh fetches
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s done, %0d errors", test_num, name, errors - test_errs);
    test_errs = errors;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial
  begin
    rst_n             = 1'b0;
    req               = 1'b0;
    pc_set            = 1'b0;
    pc_mux            = fetch_ctrl_pkg::PC_BOOT;
    exc_pc_mux        = fetch_ctrl_pkg::EXC_PC_EXCEPTION;
    irq_id            = '0;
    mepc              = '0;
    depc              = '0;
    jump_target_id    = '0;
    jump_target_ex    = '0;
    clear_instr_valid = 1'b0;
    halt_if           = 1'b0;
    id_ready          = 1'b0;
    cfg_wr            = '0;
    sh_boot           = fetch_ctrl_pkg::RESET_BOOT_ADDR;  // reset view
    sh_mtvec          = fetch_ctrl_pkg::RESET_BOOT_ADDR[31:8];
    sh_dm_halt        = '0;
    sh_dm_exc         = '0;
    exp_pc            = fetch_ctrl_pkg::RESET_BOOT_ADDR;
    last_pc           = fetch_ctrl_pkg::RESET_BOOT_ADDR;
    prev_pc           = '0;
    prev_valid        = 1'b0;
    n_loaded          = 0;
    checks            = 0;
    errors            = 0;
    test_errs         = 0;
    test_num          = 0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;
    @(posedge clk);
    req      <= 1'b1;
    id_ready <= 1'b1;

    // fetch stays idle until the boot redirect
    repeat (3) @(negedge clk);
    assert (!instr_req.req)
    else
    begin
      $display("Mismatch instr_req_o.req: got %h expected %h", instr_req.req, 1'b0);
      errors++;
    end
    assert (!if_busy)
    else
    begin
      $display("Mismatch if_busy_o: got %h expected %h", if_busy, 1'b0);
      errors++;
    end
    assert (!if_id.valid)
    else
    begin
      $display("Mismatch if_id_o.valid: got %h expected %h", if_id.valid, 1'b0);
      errors++;
    end

    cfg_write(fetch_ctrl_pkg::CFG_BOOT_ADDR, 32'h0000_2340);
    redirect(fetch_ctrl_pkg::PC_BOOT, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    // trap base now comes from the boot address
    redirect(fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(2);
    report_test("boot");

    wait_instrs(20);
    report_test("sequential stream");

    @(posedge clk);
    jump_target_id <= 32'h0000_4100;
    jump_target_ex <= 32'h0000_5202;  // low bits must be dropped
    mepc           <= 32'h0000_6300;
    depc           <= 32'h0000_7400;
    redirect(fetch_ctrl_pkg::PC_JUMP, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    redirect(fetch_ctrl_pkg::PC_BRANCH, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    redirect(fetch_ctrl_pkg::PC_MRET, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    redirect(fetch_ctrl_pkg::PC_DRET, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    redirect(fetch_ctrl_pkg::PC_FENCEI, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(3);
    report_test("redirects");

    cfg_write(fetch_ctrl_pkg::CFG_MTVEC, 32'h0000_8000);
    cfg_write(fetch_ctrl_pkg::CFG_DM_HALT, 32'h0000_9a00);
    cfg_write(fetch_ctrl_pkg::CFG_DM_EXC, 32'h0000_9b03);
    redirect(fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::EXC_PC_EXCEPTION, 5'd0);
    wait_instrs(2);
    @(negedge clk);
    imem0.take_bits(5, rnd);  // random irq id
    redirect(fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::EXC_PC_IRQ, rnd[4:0]);
    wait_instrs(2);
    redirect(fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::EXC_PC_DBD, 5'd0);
    wait_instrs(2);
    redirect(fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::EXC_PC_DBE, 5'd0);
    wait_instrs(2);
    report_test("traps");

    stall_check(1'b0);
    stall_check(1'b1);
    report_test("stall");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* testbench/tb_imem.sv */
`timescale 1ns/100ps

module tb_imem
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_bus_pkg::instr_req_t instr_req_i,
  output fetch_bus_pkg::instr_rsp_t instr_rsp_o
);

  logic [15:0] lfsr_q = 16'd40;  // random source for delays and irq ids
  logic [31:0] pend_q [$];       // granted addresses, oldest first
  logic [7:0]  delay_bits;
  int          gnt_wait;         // cycles left before gnt
  int          rsp_wait;         // cycles left before rvalid
  logic        gnt_armed;        // delay already drawn for this request
  logic        rsp_armed;        // delay already drawn for the queue head

  // contents of the whole address space, every address bit matters
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'h0000_0013;
  endfunction

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
  endtask

  // ----------------------------------------
  // bus slave
  // ----------------------------------------

  always @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_rsp_o <= '0;
      pend_q.delete();
      gnt_wait  = 0;
      rsp_wait  = 0;
      gnt_armed = 1'b0;
      rsp_armed = 1'b0;
    end
    else
    begin
      if (instr_req_i.req && instr_rsp_o.gnt)
      begin
        pend_q.push_back(instr_req_i.addr);  // handshake at this edge
        instr_rsp_o.gnt <= 1'b0;
        gnt_armed = 1'b0;
      end
      else if (instr_req_i.req)
      begin
        if (!gnt_armed)
        begin
          take_bits(2, delay_bits);  // 0 to 3 extra cycles
          gnt_wait  = delay_bits;
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0)
          instr_rsp_o.gnt <= 1'b1;
        else
          gnt_wait--;
      end
      // responses in grant order, never in the grant cycle
      instr_rsp_o.rvalid <= 1'b0;
      if (pend_q.size() != 0)
      begin
        if (!rsp_armed)
        begin
          take_bits(2, delay_bits);
          rsp_wait  = delay_bits;
          rsp_armed = 1'b1;
        end
        if (rsp_wait == 0)
        begin
          instr_rsp_o.rvalid <= 1'b1;
          instr_rsp_o.rdata  <= mem_word(pend_q.pop_front());
          rsp_armed = 1'b0;
        end
        else
          rsp_wait--;
      end
    end
  end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_i,
  input  logic                        pc_set_i,
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [4:0]                  irq_id_i,
  input  logic [31:0]                 mepc_i,
  input  logic [31:0]                 depc_i,
  input  logic [31:0]                 jump_target_id_i,
  input  logic [31:0]                 jump_target_ex_i,
  input  logic                        clear_instr_valid_i,
  input  logic                        halt_if_i,
  input  logic                        id_ready_i,
  input  fetch_bus_pkg::cfg_wr_t      cfg_wr_i,       // software config writes
  output fetch_bus_pkg::instr_req_t   instr_req_o,
  input  fetch_bus_pkg::instr_rsp_t   instr_rsp_i,
  output fetch_bus_pkg::if_id_t       if_id_o,
  output logic                        if_busy_o
);

  fetch_bus_pkg::fetch_cfg_t cfg;             // register view into fetch
  logic                      csr_mtvec_init;  // boot asks for trap base init

  fetch_cfg_regs u_cfg_regs
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr_i     (cfg_wr_i),
    .mtvec_init_i (csr_mtvec_init),
    .cfg_o        (cfg)
  );

  if_stage u_if_stage
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .cfg_i               (cfg),
    .mepc_i              (mepc_i),
    .depc_i              (depc_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .instr_req_o         (instr_req_o),
    .instr_rsp_i         (instr_rsp_i),
    .if_id_o             (if_id_o),
    .mtvec_init_o        (csr_mtvec_init),
    .if_busy_o           (if_busy_o)
  );

endmodule

/* hdl/if_stage.sv */
`timescale 1ns/100ps

module if_stage
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_i,
  input  logic                        pc_set_i,             // redirect strobe
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [4:0]                  irq_id_i,
  input  fetch_bus_pkg::fetch_cfg_t   cfg_i,
  input  logic [31:0]                 mepc_i,
  input  logic [31:0]                 depc_i,
  input  logic [31:0]                 jump_target_id_i,
  input  logic [31:0]                 jump_target_ex_i,
  input  logic                        clear_instr_valid_i,  // kill instr in ID
  input  logic                        halt_if_i,
  input  logic                        id_ready_i,
  output fetch_bus_pkg::instr_req_t   instr_req_o,
  input  fetch_bus_pkg::instr_rsp_t   instr_rsp_i,
  output fetch_bus_pkg::if_id_t       if_id_o,
  output logic                        mtvec_init_o,
  output logic                        if_busy_o
);

  logic [31:0] branch_addr;  // selected redirect target
  logic        fetch_valid, transfer;
  logic [31:0] fetch_rdata;
  logic [31:0] pc_if_q;      // pc of the fifo head
  logic        id_valid_q;
  logic [31:0] id_instr_q;
  logic [31:0] id_pc_q;

  fetch_pc_sel u_pc_sel
  (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .cfg_i            (cfg_i),
    .mepc_i           (mepc_i),
    .depc_i           (depc_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .pc_id_i          (id_pc_q),
    .branch_addr_o    (branch_addr)
  );

  prefetch_buffer u_prefetch
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (transfer),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .instr_req_o   (instr_req_o),
    .instr_rsp_i   (instr_rsp_i),
    .busy_o        (if_busy_o)
  );

  // redirect wins, head moves only when ID takes it
  assign transfer     = ~pc_set_i & fetch_valid & id_ready_i & ~halt_if_i;
  assign mtvec_init_o = pc_set_i & (pc_mux_i == fetch_ctrl_pkg::PC_BOOT);

  // ----------------------------------------
  // IF pc and IF/ID register
  // ----------------------------------------

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc_if_q    <= fetch_ctrl_pkg::RESET_BOOT_ADDR;
      id_valid_q <= 1'b0;
    end
    else
    begin
      if (pc_set_i)
        pc_if_q <= branch_addr;
      else if (transfer)
        pc_if_q <= pc_if_q + 32'd4;  // word steps only
      if (transfer)
        id_valid_q <= 1'b1;
      else if (clear_instr_valid_i)
        id_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (transfer)
    begin
      id_instr_q <= fetch_rdata;
      id_pc_q    <= pc_if_q;
    end
  end

  assign if_id_o = '{valid: id_valid_q, instr: id_instr_q, pc: id_pc_q};

  // controller must never select the unused pc source
  a_pc_mux_legal: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> pc_mux_i inside {fetch_ctrl_pkg::PC_BOOT, fetch_ctrl_pkg::PC_FENCEI,
                                  fetch_ctrl_pkg::PC_JUMP, fetch_ctrl_pkg::PC_BRANCH,
                                  fetch_ctrl_pkg::PC_EXCEPTION, fetch_ctrl_pkg::PC_MRET,
                                  fetch_ctrl_pkg::PC_DRET});

endmodule

/* hdl/prefetch_buffer.sv */
`timescale 1ns/100ps

module prefetch_buffer
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,          // fetch enable
  input  logic                       branch_i,       // redirect strobe
  input  logic [31:0]                branch_addr_i,
  input  logic                       fetch_ready_i,  // IF takes fifo head
  output logic                       fetch_valid_o,
  output logic [31:0]                fetch_rdata_o,
  output fetch_bus_pkg::instr_req_t  instr_req_o,
  input  fetch_bus_pkg::instr_rsp_t  instr_rsp_i,
  output logic                       busy_o
);

  logic [31:0] next_addr_q;  // address of the next new request
  logic [31:0] hold_addr_q;  // address of a raised, ungranted request
  logic        hold_q;       // request up and waiting for gnt
  logic        stale_q;      // held request predates the last redirect
  logic        started_q;    // nothing is fetched before the first redirect

  logic [fetch_ctrl_pkg::CNT_W-1:0]      outst_q, outst_n;      // granted, no rvalid yet
  logic [fetch_ctrl_pkg::CNT_W-1:0]      discard_q, discard_n;  // stale responses to drop
  logic [fetch_ctrl_pkg::CNT_W-1:0]      fifo_cnt_q;
  logic [fetch_ctrl_pkg::CNT_W-1:0]      live;                  // outstanding and wanted
  logic [fetch_ctrl_pkg::FIFO_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [31:0]                           fifo_mem [fetch_ctrl_pkg::PREFETCH_DEPTH];

  logic start, req, granted, rvalid, drop, push, pop;

  // ----------------------------------------
  // bus master
  // ----------------------------------------

  assign live    = outst_q - discard_q;
  // new request only with room for its response, never in a redirect cycle
  assign start   = started_q & req_i & ~branch_i & ~hold_q &
                   ((live + fifo_cnt_q) < fetch_ctrl_pkg::PREFETCH_DEPTH);
  assign req     = hold_q | start;  // a raised request stays up until gnt
  assign granted = req & instr_rsp_i.gnt;
  assign rvalid  = instr_rsp_i.rvalid;

  assign instr_req_o.req  = req;
  assign instr_req_o.addr = hold_q ? hold_addr_q : next_addr_q;

  assign drop = rvalid & (branch_i | (discard_q != '0));  // old stream
  assign push = rvalid & ~drop;
  assign pop  = fetch_ready_i & fetch_valid_o & ~branch_i;

  always_comb
  begin
    outst_n = outst_q;
    if (granted && !rvalid)
      outst_n = outst_q + 1'b1;
    else if (!granted && rvalid)
      outst_n = outst_q - 1'b1;
  end

  always_comb
  begin
    discard_n = discard_q;
    if (branch_i)
      discard_n = outst_n;  // everything still in flight is stale
    else
    begin
      if (granted && hold_q && stale_q)
        discard_n = discard_n + 1'b1;  // late grant of an old address
      if (drop)
        discard_n = discard_n - 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      next_addr_q <= fetch_ctrl_pkg::RESET_BOOT_ADDR;
      hold_q      <= 1'b0;
      stale_q     <= 1'b0;
      started_q   <= 1'b0;
      outst_q     <= '0;
      discard_q   <= '0;
    end
    else
    begin
      if (branch_i)
      begin
        started_q   <= 1'b1;
        next_addr_q <= {branch_addr_i[31:2], 2'b00};  // registered redirect
      end
      else if (granted && !(hold_q && stale_q))
        next_addr_q <= next_addr_q + 32'd4;
      hold_q    <= req & ~instr_rsp_i.gnt;
      stale_q   <= req & ~instr_rsp_i.gnt & (branch_i | stale_q);
      outst_q   <= outst_n;
      discard_q <= discard_n;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req && !instr_rsp_i.gnt && !hold_q)
      hold_addr_q <= next_addr_q;  // freeze addr while waiting for gnt
  end

  // ----------------------------------------
  // instruction fifo
  // ----------------------------------------

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else if (branch_i)
    begin
      wr_ptr_q   <= '0;  // flush on redirect
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop)
        fifo_cnt_q <= fifo_cnt_q + 1'b1;
      else if (pop && !push)
        fifo_cnt_q <= fifo_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr_q] <= instr_rsp_i.rdata;
  end

  assign fetch_valid_o = (fifo_cnt_q != '0);
  assign fetch_rdata_o = fifo_mem[rd_ptr_q];
  assign busy_o        = req | (outst_q != '0);

  // ----------------------------------------
  // checks
  // ----------------------------------------

  a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (fifo_cnt_q < fetch_ctrl_pkg::PREFETCH_DEPTH) || pop);

  a_rvalid_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> (outst_q != '0));

endmodule

/* hdl/fetch_pc_sel.sv */
`timescale 1ns/100ps

module fetch_pc_sel
(
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,          // next pc source
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,      // trap target
  input  logic [4:0]                  irq_id_i,          // vector index
  input  fetch_bus_pkg::fetch_cfg_t   cfg_i,
  input  logic [31:0]                 mepc_i,
  input  logic [31:0]                 depc_i,
  input  logic [31:0]                 jump_target_id_i,
  input  logic [31:0]                 jump_target_ex_i,
  input  logic [31:0]                 pc_id_i,           // pc of instr in ID
  output logic [31:0]                 branch_addr_o
);

  logic [31:0] exc_pc;     // trap handler address
  logic [31:0] next_addr;  // raw selection, before alignment

  // ----------------------------------------
  // trap vector
  // ----------------------------------------

  always_comb
  begin
    case (exc_pc_mux_i)
      fetch_ctrl_pkg::EXC_PC_EXCEPTION: exc_pc = {cfg_i.mtvec_base, 8'h00};  // all to base
      fetch_ctrl_pkg::EXC_PC_IRQ:       exc_pc = {cfg_i.mtvec_base, 1'b0, irq_id_i, 2'b00};
      fetch_ctrl_pkg::EXC_PC_DBD:       exc_pc = cfg_i.dm_halt_addr;
      fetch_ctrl_pkg::EXC_PC_DBE:       exc_pc = cfg_i.dm_exc_addr;
      default:                          exc_pc = {cfg_i.mtvec_base, 8'h00};
    endcase
  end

  // ----------------------------------------
  // next fetch address
  // ----------------------------------------

  always_comb
  begin
    next_addr = cfg_i.boot_addr;  // also covers the unused code
    case (pc_mux_i)
      fetch_ctrl_pkg::PC_BOOT:      next_addr = cfg_i.boot_addr;
      fetch_ctrl_pkg::PC_JUMP:      next_addr = jump_target_id_i;
      fetch_ctrl_pkg::PC_BRANCH:    next_addr = jump_target_ex_i;
      fetch_ctrl_pkg::PC_EXCEPTION: next_addr = exc_pc;
      fetch_ctrl_pkg::PC_MRET:      next_addr = mepc_i;         // back from trap
      fetch_ctrl_pkg::PC_DRET:      next_addr = depc_i;         // back from debug
      fetch_ctrl_pkg::PC_FENCEI:    next_addr = pc_id_i + 32'd4;  // forces a refetch
      default: ;
    endcase
  end

  // no compressed instructions, so every target is a word address
  assign branch_addr_o = {next_addr[31:2], 2'b00};

endmodule

/* hdl/fetch_cfg_regs.sv */
`timescale 1ns/100ps

module fetch_cfg_regs
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  fetch_bus_pkg::cfg_wr_t     cfg_wr_i,      // strobe write port
  input  logic                       mtvec_init_i,  // boot request from fetch
  output fetch_bus_pkg::fetch_cfg_t  cfg_o
);

  logic [31:0] boot_addr_q;
  logic [23:0] mtvec_base_q;
  logic [31:0] dm_halt_addr_q;
  logic [31:0] dm_exc_addr_q;

  // ----------------------------------------
  // register file
  // ----------------------------------------

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      boot_addr_q    <= fetch_ctrl_pkg::RESET_BOOT_ADDR;
      mtvec_base_q   <= fetch_ctrl_pkg::RESET_BOOT_ADDR[31:8];
      dm_halt_addr_q <= '0;
      dm_exc_addr_q  <= '0;
    end
    else
    begin
      if (mtvec_init_i)
        mtvec_base_q <= boot_addr_q[31:8];  // trap base follows boot address
      if (cfg_wr_i.we)
      begin
        // later assignment wins, so a MTVEC write beats the init
        case (cfg_wr_i.addr)
          fetch_ctrl_pkg::CFG_BOOT_ADDR: boot_addr_q    <= {cfg_wr_i.wdata[31:2], 2'b00};
          fetch_ctrl_pkg::CFG_MTVEC:     mtvec_base_q   <= cfg_wr_i.wdata[31:8];
          fetch_ctrl_pkg::CFG_DM_HALT:   dm_halt_addr_q <= {cfg_wr_i.wdata[31:2], 2'b00};
          fetch_ctrl_pkg::CFG_DM_EXC:    dm_exc_addr_q  <= {cfg_wr_i.wdata[31:2], 2'b00};
          default: ;
        endcase
      end
    end
  end

  assign cfg_o.boot_addr    = boot_addr_q;
  assign cfg_o.mtvec_base   = mtvec_base_q;
  assign cfg_o.dm_halt_addr = dm_halt_addr_q;
  assign cfg_o.dm_exc_addr  = dm_exc_addr_q;

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // all four codes are mapped, only an unknown address lies outside the map
  a_cfg_addr_legal: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_wr_i.we |-> !$isunknown(cfg_wr_i.addr));

endmodule

/* hdl/fetch_bus_pkg.sv */
package fetch_bus_pkg;

  // ----------------------------------------
  // instruction bus
  // ----------------------------------------

  // master side, held until gnt
  typedef struct packed {
    logic        req;
    logic [31:0] addr;  // always word aligned
  } instr_req_t;

  // slave side
  typedef struct packed {
    logic        gnt;     // request accepted
    logic        rvalid;  // one per grant, in order
    logic [31:0] rdata;
  } instr_rsp_t;

  // ----------------------------------------
  // configuration access
  // ----------------------------------------

  // single-cycle write strobe, no back-pressure
  typedef struct packed {
    logic                      we;
    fetch_ctrl_pkg::cfg_addr_e addr;
    logic [31:0]               wdata;
  } cfg_wr_t;

  // register view seen by the fetch stage
  typedef struct packed {
    logic [31:0] boot_addr;
    logic [23:0] mtvec_base;  // vector table base, 256 byte aligned
    logic [31:0] dm_halt_addr;
    logic [31:0] dm_exc_addr;
  } fetch_cfg_t;

  // IF/ID pipeline payload
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_t;

endpackage

/* hdl/fetch_ctrl_pkg.sv */
package fetch_ctrl_pkg;

  // ----------------------------------------
  // fetch sizing
  // ----------------------------------------

  localparam int unsigned PREFETCH_DEPTH = 2;  // fifo words, also in-flight limit
  localparam int unsigned FIFO_PTR_W     = $clog2(PREFETCH_DEPTH);  // depth is a power of two
  // counters must hold live plus stale transactions after a redirect
  localparam int unsigned CNT_W          = $clog2(2 * PREFETCH_DEPTH + 1);

  localparam logic [31:0] RESET_BOOT_ADDR = 32'h0000_1000;  // boot address out of reset

  // ----------------------------------------
  // pc source, driven together with pc_set
  // ----------------------------------------

  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,  // refetch after the fence
    PC_JUMP      = 3'b010,  // target from ID
    PC_BRANCH    = 3'b011,  // target from EX
    PC_EXCEPTION = 3'b100,  // trap vector, see exc_pc_mux_e
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;  // 3'b110 stays unused

  // trap target
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,  // mtvec base
    EXC_PC_IRQ       = 2'b01,  // vectored by irq id
    EXC_PC_DBD       = 2'b10,  // debug halt
    EXC_PC_DBE       = 2'b11   // exception while in debug
  } exc_pc_mux_e;

  // configuration register map
  typedef enum logic [1:0] {
    CFG_BOOT_ADDR = 2'b00,
    CFG_MTVEC     = 2'b01,
    CFG_DM_HALT   = 2'b10,
    CFG_DM_EXC    = 2'b11
  } cfg_addr_e;

endpackage
